//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mem_ctrl
FILELIST   := tb.f
VFLAGS     := --timing --assert --top-module $(TOP)
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary -j 0
OBJ_DIR    := obj_dir
PASS_MSG   := Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- access_arbiter.sv
`timescale 1ns/100ps

module access_arbiter import mem_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  if_req,
    input  addr_t                 if_pc,
    input  logic                  ls_req,
    input  mem_op_e               ls_op,
    input  addr_t                 ls_addr,
    input  logic                  rollback,
    output logic                  if_valid,
    output word_t                 if_inst,
    output logic                  ls_valid,
    output word_t                 ls_value,
    store_queue_if.arbiter        sq,
    mem_job_if.arbiter            job
);

    arb_state_e state;
    job_kind_e  kind_q;

    // pending requests
    logic       fetch_pend;
    addr_t      fetch_pc;
    logic       load_pend;
    mem_op_e    load_op;
    addr_t      load_addr;

    // result of a read in flight is thrown away after rollback
    logic       drop_q;

    logic       start_q;
    logic       pop_q;
    mem_op_e    op_q;
    addr_t      addr_q;
    word_t      wdata_q;

    logic       can_issue;
    logic       pick_store;
    logic       pick_fetch;
    logic       pick_load;
    logic       keep_result;

    assign can_issue = (state == ARB_IDLE) && !job.busy;

    // stores first, then fetch, then load
    assign pick_store = can_issue && sq.head_valid;
    assign pick_fetch = can_issue && !sq.head_valid && fetch_pend && !rollback;
    assign pick_load  = can_issue && !sq.head_valid && !fetch_pend && load_pend && !rollback;

    assign keep_result = job.done && !drop_q && !rollback;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pend <= 1'b0;
            load_pend  <= 1'b0;
        end else if (rollback) begin
            fetch_pend <= 1'b0;
            load_pend  <= 1'b0;
        end else begin
            if (if_req) begin
                fetch_pend <= 1'b1;
            end else if (pick_fetch) begin
                fetch_pend <= 1'b0;
            end
            if (ls_req) begin
                load_pend <= 1'b1;
            end else if (pick_load) begin
                load_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ARB_IDLE;
            kind_q   <= JOB_FETCH;
            drop_q   <= 1'b0;
            start_q  <= 1'b0;
            pop_q    <= 1'b0;
            if_valid <= 1'b0;
            ls_valid <= 1'b0;
        end else begin
            start_q  <= pick_store || pick_fetch || pick_load;
            pop_q    <= pick_store;
            if_valid <= keep_result && (kind_q == JOB_FETCH);
            ls_valid <= keep_result && (kind_q == JOB_LOAD);
            case (state)
                ARB_IDLE: begin
                    drop_q <= 1'b0;
                    if (pick_store) begin
                        state  <= ARB_BUSY;
                        kind_q <= JOB_STORE;
                    end else if (pick_fetch) begin
                        state  <= ARB_BUSY;
                        kind_q <= JOB_FETCH;
                    end else if (pick_load) begin
                        state  <= ARB_BUSY;
                        kind_q <= JOB_LOAD;
                    end
                end
                ARB_BUSY: begin
                    // a store always finishes, reads lose their result
                    if (rollback && kind_q != JOB_STORE) begin
                        drop_q <= 1'b1;
                    end
                    if (job.done) begin
                        state  <= ARB_IDLE;
                        drop_q <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (if_req) begin
            fetch_pc <= if_pc;
        end
        if (ls_req) begin
            load_op   <= ls_op;
            load_addr <= ls_addr;
        end
        if (pick_store) begin
            op_q    <= sq.head_op;
            addr_q  <= sq.head_addr;
            wdata_q <= sq.head_data;
        end else if (pick_fetch) begin
            op_q   <= OP_LW;
            addr_q <= fetch_pc;
        end else if (pick_load) begin
            op_q   <= load_op;
            addr_q <= load_addr;
        end
        if (keep_result && kind_q == JOB_FETCH) begin
            if_inst <= job.rdata;
        end
        if (keep_result && kind_q == JOB_LOAD) begin
            ls_value <= job.rdata;
        end
    end

    assign job.start = start_q;
    assign job.op    = op_q;
    assign job.addr  = addr_q;
    assign job.wdata = wdata_q;
    assign sq.pop    = pop_q;

    // fetch unit waits for its result or a rollback
    a_single_fetch: assert property (
        @(posedge clk) disable iff (!rst_n)
        if_req |-> !fetch_pend
    );

endmodule

//--- byte_sequencer.sv
`timescale 1ns/100ps

module byte_sequencer import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    mem_job_if.sequencer      job,
    output logic              ram_wr,
    output addr_t             ram_addr,
    output byte_t             ram_wdata,
    input  byte_t             ram_rdata
);

    seq_state_e state;
    mem_op_e    op_q;
    addr_t      base_q;
    word_t      wdata_q;
    logic [1:0] last_idx;

    // next byte to put on the bus
    logic [1:0] issue_idx;

    // read return tracking
    logic       rd_issue;
    logic [1:0] rd_pipe;
    logic [1:0] cap_idx;
    word_t      rbuf;

    logic       done_q;
    word_t      rdata_ext;

    // index of the last byte, one less than the byte count
    function automatic logic [1:0] last_byte(input mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: last_byte = 2'd0;
            OP_LH, OP_LHU, OP_SH: last_byte = 2'd1;
            default:              last_byte = 2'd3;
        endcase
    endfunction

    function automatic logic is_store(input mem_op_e op);
        is_store = (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SEQ_IDLE;
            ram_wr    <= 1'b0;
            ram_addr  <= '0;
            issue_idx <= '0;
            rd_issue  <= 1'b0;
            rd_pipe   <= '0;
            cap_idx   <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q  <= 1'b0;
            // bytes come back two cycles after their address
            rd_pipe <= {rd_pipe[0], rd_issue};
            if (rd_pipe[1]) begin
                cap_idx <= cap_idx + 2'd1;
            end
            case (state)
                SEQ_IDLE: begin
                    ram_wr   <= 1'b0;
                    ram_addr <= '0;
                    rd_issue <= 1'b0;
                    if (job.start) begin
                        ram_addr  <= job.addr;
                        ram_wr    <= is_store(job.op);
                        rd_issue  <= !is_store(job.op);
                        issue_idx <= 2'd1;
                        cap_idx   <= '0;
                        if (last_byte(job.op) == 2'd0) begin
                            state <= SEQ_DRAIN;
                        end else begin
                            state <= SEQ_RUN;
                        end
                    end
                end
                SEQ_RUN: begin
                    ram_addr  <= base_q + addr_t'(issue_idx);
                    issue_idx <= issue_idx + 2'd1;
                    if (issue_idx == last_idx) begin
                        state <= SEQ_DRAIN;
                    end
                end
                SEQ_DRAIN: begin
                    ram_wr   <= 1'b0;
                    ram_addr <= '0;
                    rd_issue <= 1'b0;
                    // writes end right after the last byte
                    if (is_store(op_q)) begin
                        done_q <= 1'b1;
                        state  <= SEQ_IDLE;
                    end else if (rd_pipe[1] && cap_idx == last_idx) begin
                        done_q <= 1'b1;
                        state  <= SEQ_IDLE;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && job.start) begin
            op_q      <= job.op;
            base_q    <= job.addr;
            wdata_q   <= job.wdata;
            last_idx  <= last_byte(job.op);
            ram_wdata <= job.wdata[7:0];
        end else if (state == SEQ_RUN) begin
            ram_wdata <= wdata_q[{issue_idx, 3'b000} +: 8];
        end
        if (rd_pipe[1]) begin
            rbuf[{cap_idx, 3'b000} +: 8] <= ram_rdata;
        end
    end

    // sign or zero extension of narrow loads
    always_comb begin
        case (op_q)
            OP_LB:   rdata_ext = {{24{rbuf[7]}}, rbuf[7:0]};
            OP_LBU:  rdata_ext = {24'd0, rbuf[7:0]};
            OP_LH:   rdata_ext = {{16{rbuf[15]}}, rbuf[15:0]};
            OP_LHU:  rdata_ext = {16'd0, rbuf[15:0]};
            default: rdata_ext = rbuf;
        endcase
    end

    assign job.busy  = (state != SEQ_IDLE);
    assign job.done  = done_q;
    assign job.rdata = rdata_ext;

    // arbiter must wait for the previous job
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        job.start |-> !job.busy
    );

endmodule

//--- mem_ctrl.sv
`timescale 1ns/100ps

module mem_ctrl import mem_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    // reorder buffer
    input  logic    rob_valid,
    input  mem_op_e rob_op,
    input  addr_t   rob_addr,
    input  word_t   rob_data,
    // instruction fetch
    input  logic    if_req,
    input  addr_t   if_pc,
    output logic    if_valid,
    output word_t   if_inst,
    // load unit
    input  logic    ls_req,
    input  mem_op_e ls_op,
    input  addr_t   ls_addr,
    output logic    ls_valid,
    output word_t   ls_value,
    output logic    sq_full,
    input  logic    rollback,
    // byte-wide ram
    output logic    ram_wr,
    output addr_t   ram_addr,
    output byte_t   ram_wdata,
    input  byte_t   ram_rdata
);

    store_queue_if sq_bus ();
    mem_job_if     job_bus ();

    store_queue u_store_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rob_valid),
        .push_op   (rob_op),
        .push_addr (rob_addr),
        .push_data (rob_data),
        .full      (sq_full),
        .sq        (sq_bus.queue)
    );

    access_arbiter u_access_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_req   (if_req),
        .if_pc    (if_pc),
        .ls_req   (ls_req),
        .ls_op    (ls_op),
        .ls_addr  (ls_addr),
        .rollback (rollback),
        .if_valid (if_valid),
        .if_inst  (if_inst),
        .ls_valid (ls_valid),
        .ls_value (ls_value),
        .sq       (sq_bus.arbiter),
        .job      (job_bus.arbiter)
    );

    byte_sequencer u_byte_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .job       (job_bus.sequencer),
        .ram_wr    (ram_wr),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

endmodule

//--- mem_job_if.sv
`timescale 1ns/100ps

interface mem_job_if import mem_pkg::*; ();

    // request side, start is a single-cycle pulse
    logic    start;
    mem_op_e op;
    addr_t   addr;
    word_t   wdata;

    // completion side
    logic    busy;
    logic    done;
    // already extended, valid with done on reads
    word_t   rdata;

    modport arbiter (
        output start,
        output op,
        output addr,
        output wdata,
        input  busy,
        input  done,
        input  rdata
    );

    modport sequencer (
        input  start,
        input  op,
        input  addr,
        input  wdata,
        output busy,
        output done,
        output rdata
    );

endinterface

//--- mem_pkg.sv
package mem_pkg;

    // address and data widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // load and store operations, fetch uses OP_LW
    typedef enum logic [2:0] {
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW
    } mem_op_e;

    // store queue sizing
    localparam int SQ_DEPTH = 8;

    typedef logic [2:0] sq_idx_t;
    typedef logic [3:0] sq_count_t;

    // one below depth so a store pushed in the same cycle still fits
    localparam sq_count_t SQ_FULL_LEVEL = 4'd7;

    // job owner, used to route results back
    typedef enum logic [1:0] {
        JOB_FETCH,
        JOB_LOAD,
        JOB_STORE
    } job_kind_e;

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_DRAIN
    } seq_state_e;

endpackage

//--- store_queue.sv
`timescale 1ns/100ps

module store_queue import mem_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          push,
    input  mem_op_e       push_op,
    input  addr_t         push_addr,
    input  word_t         push_data,
    output logic          full,
    store_queue_if.queue  sq
);

    // entry storage
    mem_op_e   op_mem   [SQ_DEPTH];
    addr_t     addr_mem [SQ_DEPTH];
    word_t     data_mem [SQ_DEPTH];

    sq_idx_t   head;
    sq_idx_t   tail;
    sq_count_t count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + sq_idx_t'(1);
            end
            if (sq.pop) begin
                head <= head + sq_idx_t'(1);
            end
            // push and pop together keep the count
            case ({push, sq.pop})
                2'b10:   count <= count + sq_count_t'(1);
                2'b01:   count <= count - sq_count_t'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[tail]   <= push_op;
            addr_mem[tail] <= push_addr;
            data_mem[tail] <= push_data;
        end
    end

    assign sq.head_valid = (count != '0);
    assign sq.head_op    = op_mem[head];
    assign sq.head_addr  = addr_mem[head];
    assign sq.head_data  = data_mem[head];

    // level flag straight from occupancy
    assign full = (count >= SQ_FULL_LEVEL);

    // rob must honour full
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> (count != sq_count_t'(SQ_DEPTH))
    );

    // arbiter pops only a valid head
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        sq.pop |-> (count != '0)
    );

endmodule

//--- store_queue_if.sv
`timescale 1ns/100ps

interface store_queue_if import mem_pkg::*; ();

    // head entry of the queue
    logic    head_valid;
    addr_t   head_addr;
    word_t   head_data;
    mem_op_e head_op;

    // removes the head, only while head_valid
    logic    pop;

    modport queue (
        output head_valid,
        output head_addr,
        output head_data,
        output head_op,
        input  pop
    );

    modport arbiter (
        input  head_valid,
        input  head_addr,
        input  head_data,
        input  head_op,
        output pop
    );

endinterface

//--- tb.f
mem_pkg.sv
store_queue_if.sv
mem_job_if.sv
store_queue.sv
access_arbiter.sv
byte_sequencer.sv
mem_ctrl.sv
tb_mem_ctrl.sv

//--- tb_mem_ctrl.sv
`timescale 1ns/100ps

module tb_mem_ctrl import mem_pkg::*; ();

    localparam int RAM_BYTES    = 1024;
    localparam int WAIT_LIMIT   = 300;
    localparam int QUIET_CYCLES = 60;
    localparam logic [31:0] SEED = 32'hcf19c8fb;

    typedef enum logic [2:0] {
        K_FETCH,
        K_LOAD,
        K_STORE,
        K_BURST,
        K_ROLLBACK
    } step_kind_e;

    // burst steps use data as the number of stores
    typedef struct packed {
        step_kind_e kind;
        mem_op_e    op;
        addr_t      addr;
        word_t      data;
    } step_t;

    localparam int NUM_STEPS = 26;

    step_t steps [NUM_STEPS] = '{
        '{K_FETCH,    OP_LW,  32'h0000_0040, 32'h0000_0000},
        '{K_FETCH,    OP_LW,  32'h0000_03fa, 32'h0000_0000},
        '{K_LOAD,     OP_LB,  32'h0000_0123, 32'h0000_0000},
        '{K_LOAD,     OP_LBU, 32'h0000_0123, 32'h0000_0000},
        '{K_LOAD,     OP_LH,  32'h0000_0231, 32'h0000_0000},
        '{K_LOAD,     OP_LHU, 32'h0000_0231, 32'h0000_0000},
        '{K_LOAD,     OP_LW,  32'h0000_02e5, 32'h0000_0000},
        // known bytes with the top bit set and clear
        '{K_STORE,    OP_SW,  32'h0000_0100, 32'h80f1_7f05},
        '{K_LOAD,     OP_LB,  32'h0000_0100, 32'h0000_0000},
        '{K_LOAD,     OP_LB,  32'h0000_0103, 32'h0000_0000},
        '{K_LOAD,     OP_LBU, 32'h0000_0103, 32'h0000_0000},
        '{K_LOAD,     OP_LH,  32'h0000_0100, 32'h0000_0000},
        '{K_LOAD,     OP_LH,  32'h0000_0102, 32'h0000_0000},
        '{K_LOAD,     OP_LHU, 32'h0000_0102, 32'h0000_0000},
        '{K_LOAD,     OP_LW,  32'h0000_0100, 32'h0000_0000},
        // merge of word, half and byte stores
        '{K_STORE,    OP_SW,  32'h0000_0200, 32'h1122_3344},
        '{K_STORE,    OP_SH,  32'h0000_0201, 32'h0000_a5b6},
        '{K_STORE,    OP_SB,  32'h0000_0203, 32'h0000_00c7},
        '{K_LOAD,     OP_LW,  32'h0000_0200, 32'h0000_0000},
        '{K_BURST,    OP_SW,  32'h0000_0300, 32'd12},
        '{K_STORE,    OP_SW,  32'h0000_0080, 32'hdead_beef},
        '{K_STORE,    OP_SB,  32'h0000_0084, 32'h0000_005a},
        '{K_ROLLBACK, OP_LW,  32'h0000_0080, 32'h0000_0000},
        '{K_LOAD,     OP_LW,  32'h0000_0080, 32'h0000_0000},
        '{K_LOAD,     OP_LBU, 32'h0000_0084, 32'h0000_0000},
        '{K_FETCH,    OP_LW,  32'h0000_0080, 32'h0000_0000}
    };

    logic    clk;
    logic    rst_n;
    logic    rob_valid;
    mem_op_e rob_op;
    addr_t   rob_addr;
    word_t   rob_data;
    logic    if_req;
    addr_t   if_pc;
    logic    if_valid;
    word_t   if_inst;
    logic    ls_req;
    mem_op_e ls_op;
    addr_t   ls_addr;
    logic    ls_valid;
    word_t   ls_value;
    logic    sq_full;
    logic    rollback;
    logic    ram_wr;
    addr_t   ram_addr;
    byte_t   ram_wdata;
    byte_t   ram_rdata = '0;

    byte_t       ram_mem [RAM_BYTES];
    byte_t       ref_mem [RAM_BYTES];
    byte_t       rd_stage = '0;
    logic [31:0] rnd;
    int          value_errs;
    int          timeout_errs;

    mem_ctrl dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .rob_valid (rob_valid),
        .rob_op    (rob_op),
        .rob_addr  (rob_addr),
        .rob_data  (rob_data),
        .if_req    (if_req),
        .if_pc     (if_pc),
        .if_valid  (if_valid),
        .if_inst   (if_inst),
        .ls_req    (ls_req),
        .ls_op     (ls_op),
        .ls_addr   (ls_addr),
        .ls_valid  (ls_valid),
        .ls_value  (ls_value),
        .sq_full   (sq_full),
        .rollback  (rollback),
        .ram_wr    (ram_wr),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // byte ram, read data two cycles behind the address
    always @(posedge clk) begin
        if (ram_wr) begin
            ram_mem[ram_addr[9:0]] <= ram_wdata;
        end
        rd_stage  <= ram_mem[ram_addr[9:0]];
        ram_rdata <= rd_stage;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        xorshift32 = y ^ (y << 5);
    endfunction

    // little-endian read of the reference memory, then extension
    function automatic word_t expect_load(input mem_op_e op, input addr_t a);
        word_t raw;
        raw = '0;
        for (int k = 0; k < 4; k++) begin
            raw[8*k +: 8] = ref_mem[a[9:0] + 10'(k)];
        end
        case (op)
            OP_LB:   expect_load = {{24{raw[7]}}, raw[7:0]};
            OP_LBU:  expect_load = {24'd0, raw[7:0]};
            OP_LH:   expect_load = {{16{raw[15]}}, raw[15:0]};
            OP_LHU:  expect_load = {16'd0, raw[15:0]};
            default: expect_load = raw;
        endcase
    endfunction

    task automatic ref_store(input mem_op_e op, input addr_t a, input word_t d);
        int n;
        case (op)
            OP_SB:   n = 1;
            OP_SH:   n = 2;
            default: n = 4;
        endcase
        for (int k = 0; k < n; k++) begin
            ref_mem[a[9:0] + 10'(k)] = d[8*k +: 8];
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR %s: got %08h, expected %08h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR %s: got %08h, expected %08h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // returns at the edge where the result pulse is seen
    task automatic wait_valid(input logic fetch_side, input int step, output logic seen);
        int n;
        n = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
            seen = fetch_side ? if_valid : ls_valid;
        end
        if (!seen) begin
            timeout_errs++;
            $display("timeout: no %s result for step %0d", fetch_side ? "fetch" : "load", step);
        end
    endtask

    task automatic fetch_word(input addr_t pc, input int step);
        logic seen;
        @(posedge clk);
        if_req <= 1'b1;
        if_pc  <= pc;
        @(posedge clk);
        if_req <= 1'b0;
        wait_valid(1'b1, step, seen);
        if (seen) begin
            check_word("if_inst", if_inst, expect_load(OP_LW, pc));
        end
    endtask

    task automatic load_value(input mem_op_e op, input addr_t a, input int step);
        logic seen;
        @(posedge clk);
        ls_req  <= 1'b1;
        ls_op   <= op;
        ls_addr <= a;
        @(posedge clk);
        ls_req <= 1'b0;
        wait_valid(1'b0, step, seen);
        if (seen) begin
            check_word("ls_value", ls_value, expect_load(op, a));
        end
    endtask

    task automatic push_store(input mem_op_e op, input addr_t a, input word_t d);
        int n;
        n = 0;
        @(posedge clk);
        while (sq_full && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (sq_full) begin
            timeout_errs++;
            $display("timeout: store queue stayed full, store to %08h not pushed", a);
        end else begin
            rob_valid <= 1'b1;
            rob_op    <= op;
            rob_addr  <= a;
            rob_data  <= d;
            ref_store(op, a, d);
            @(posedge clk);
            rob_valid <= 1'b0;
        end
    endtask

    // overlapping word stores, so only in-order draining gives the reference
    task automatic burst_stores(input addr_t base, input int count, input int step);
        int   i;
        int   n;
        logic saw_full;
        word_t d;
        i = 0;
        n = 0;
        saw_full = 1'b0;
        while (i < count && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
            if (sq_full) begin
                saw_full = 1'b1;
                rob_valid <= 1'b0;
            end else begin
                rnd = xorshift32(rnd);
                d = rnd;
                rob_valid <= 1'b1;
                rob_op    <= OP_SW;
                rob_addr  <= base + addr_t'(2 * i);
                rob_data  <= d;
                ref_store(OP_SW, base + addr_t'(2 * i), d);
                i++;
            end
        end
        @(posedge clk);
        rob_valid <= 1'b0;
        if (i < count) begin
            timeout_errs++;
            $display("timeout: burst at step %0d pushed only %0d stores", step, i);
        end
        check_flag("sq_full", saw_full, 1'b1);
        for (int j = 0; j < (2 * count + 5) / 4; j++) begin
            load_value(OP_LW, base + addr_t'(4 * j), step);
        end
    endtask

    task automatic rollback_load(input mem_op_e op, input addr_t a);
        logic stray;
        stray = 1'b0;
        @(posedge clk);
        ls_req  <= 1'b1;
        ls_op   <= op;
        ls_addr <= a;
        @(posedge clk);
        ls_req   <= 1'b0;
        rollback <= 1'b1;
        @(posedge clk);
        rollback <= 1'b0;
        for (int n = 0; n < QUIET_CYCLES; n++) begin
            @(posedge clk);
            if (ls_valid) begin
                stray = 1'b1;
            end
        end
        check_flag("ls_valid", stray, 1'b0);
    endtask

    initial begin
        rst_n     = 1'b0;
        rob_valid = 1'b0;
        rob_op    = OP_SW;
        rob_addr  = '0;
        rob_data  = '0;
        if_req    = 1'b0;
        if_pc     = '0;
        ls_req    = 1'b0;
        ls_op     = OP_LW;
        ls_addr   = '0;
        rollback  = 1'b0;
        value_errs   = 0;
        timeout_errs = 0;

        // preload, each byte mixes the generator with its own address
        rnd = SEED;
        for (int i = 0; i < RAM_BYTES; i++) begin
            rnd = xorshift32(rnd);
            ram_mem[i] = rnd[7:0] ^ byte_t'(i) ^ byte_t'(i >> 8);
            ref_mem[i] = ram_mem[i];
        end

        repeat (4) @(posedge clk);
        check_flag("ram_wr", ram_wr, 1'b0);
        check_flag("if_valid", if_valid, 1'b0);
        check_flag("ls_valid", ls_valid, 1'b0);
        check_flag("sq_full", sq_full, 1'b0);
        check_addr("ram_addr", ram_addr, '0);
        rst_n <= 1'b1;

        for (int s = 0; s < NUM_STEPS; s++) begin
            case (steps[s].kind)
                K_FETCH:    fetch_word(steps[s].addr, s);
                K_LOAD:     load_value(steps[s].op, steps[s].addr, s);
                K_STORE:    push_store(steps[s].op, steps[s].addr, steps[s].data);
                K_BURST:    burst_stores(steps[s].addr, int'(steps[s].data), s);
                K_ROLLBACK: rollback_load(steps[s].op, steps[s].addr);
                default:    value_errs = value_errs;
            endcase
        end

        repeat (4) @(posedge clk);
        $display("errors: %0d value mismatches, %0d timeouts", value_errs, timeout_errs);
        if (value_errs == 0 && timeout_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
